// ==== source/board_pkg.sv ====
// shared constants for the switch report design, imported by the filter, reporter and transmitter
`default_nettype none

package board_pkg;

  // board pin counts
  localparam int NUM_SWITCHES = 4;
  localparam int NUM_LEDS     = 8;

  // led upper nibble carries the change count, lower nibble the switch state
  localparam int CHG_CNT_W = NUM_LEDS - NUM_SWITCHES;

  // uart bit time in system clocks
  localparam int CLKS_PER_BIT = 16;
  localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

  // 8N1 character: start bit, 8 data bits, stop bit
  localparam int UART_FRAME_BITS = 10;
  localparam int BIT_IDX_W       = $clog2(UART_FRAME_BITS);

  // cycles a synchronized switch value must hold before it is accepted
  localparam int FILTER_CYCLES = 8;
  // counter saturates at FILTER_CYCLES, so it needs one extra code
  localparam int FILTER_CNT_W  = $clog2(FILTER_CYCLES + 1);

  // transmit queue depth, also the reporter's starting credit count
  localparam int TX_CREDITS = 2;
  localparam int QPTR_W     = (TX_CREDITS > 1) ? $clog2(TX_CREDITS) : 1;
  // holds 0..TX_CREDITS, shared by queue fill level and credit counter
  localparam int QCNT_W     = $clog2(TX_CREDITS + 1);

  // first byte of every report frame, ASCII 'S'
  localparam logic [7:0] FRAME_HEADER = 8'h53;

endpackage

`default_nettype wire

// ==== source/switch_filter.sv ====
// dip switch synchronizer and debouncer, reports each newly accepted switch state with a pulse
`timescale 1ns/1ps
`default_nettype none

module switch_filter (
  input  logic                              clk,
  input  logic                              i_reset,
  input  logic [board_pkg::NUM_SWITCHES-1:0] i_switch,
  output logic [board_pkg::NUM_SWITCHES-1:0] o_state,
  output logic                              o_change
);
  import board_pkg::*;

  // two flop synchronizer stages
  logic [NUM_SWITCHES-1:0] sync_q1;
  logic [NUM_SWITCHES-1:0] sync_q2;
  // synchronized value one cycle back, used to detect movement
  logic [NUM_SWITCHES-1:0] last_q;
  // cycles the synchronized value has stayed put
  logic [FILTER_CNT_W-1:0] hold_cnt;
  logic                    steady;
  logic                    accept;

  // pins are asynchronous, bring them into the clk domain first
  always_ff @(posedge clk) begin
    if (i_reset) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
      last_q  <= '0;
    end else begin
      sync_q1 <= i_switch;
      sync_q2 <= sync_q1;
      last_q  <= sync_q2;
    end
  end

  assign steady = (sync_q2 == last_q);

  // any movement restarts the count
  // count saturates so a held value is only timed once
  always_ff @(posedge clk) begin
    if (i_reset) begin
      hold_cnt <= '0;
    end else if (!steady) begin
      hold_cnt <= '0;
    end else if (hold_cnt != FILTER_CNT_W'(FILTER_CYCLES)) begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // value has held long enough and is not the one already reported
  assign accept = steady &&
                  (hold_cnt == FILTER_CNT_W'(FILTER_CYCLES - 1)) &&
                  (sync_q2 != o_state);

  // o_state takes the new value on the same edge that raises o_change
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_state  <= '0;
      o_change <= 1'b0;
    end else begin
      o_change <= accept;
      if (accept) begin
        o_state <= sync_q2;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/status_reporter.sv ====
// counts accepted switch changes, drives the leds and builds two byte uart reports under credit
`timescale 1ns/1ps
`default_nettype none

module status_reporter (
  input  logic                              clk,
  input  logic                              i_reset,
  input  logic [board_pkg::NUM_SWITCHES-1:0] i_state,
  input  logic                              i_change,
  input  logic                              i_credit,
  output logic [board_pkg::NUM_LEDS-1:0]     o_led,
  output logic                              o_tx_valid,
  output logic [7:0]                        o_tx_data
);
  import board_pkg::*;

  // wrapping count of accepted changes
  logic [CHG_CNT_W-1:0]    chg_cnt;
  // latest accepted switch state
  logic [NUM_SWITCHES-1:0] state_q;
  // frame progress flags
  // hdr_pend: header byte still owed
  // data_pend: data byte still owed
  logic                    hdr_pend;
  logic                    data_pend;
  // free entries left in the transmitter queue
  logic [QCNT_W-1:0]       credit_cnt;
  logic                    send_hdr;
  logic                    send_data;
  logic                    new_frame;

  // led and data byte share the same layout
  assign o_led = {chg_cnt, state_q};

  always_ff @(posedge clk) begin
    if (i_reset) begin
      chg_cnt <= '0;
      state_q <= '0;
    end else if (i_change) begin
      chg_cnt <= chg_cnt + 1'b1;
      state_q <= i_state;
    end
  end

  // only offer a byte when the queue is known to have room
  assign o_tx_valid = (hdr_pend || data_pend) && (credit_cnt != '0);
  // header always goes first, data byte is read live so it shows the newest state
  assign o_tx_data  = hdr_pend ? FRAME_HEADER : {chg_cnt, state_q};

  assign send_hdr  = o_tx_valid && hdr_pend;
  assign send_data = o_tx_valid && !hdr_pend && data_pend;

  // a change while the data byte is still owed folds into that frame,
  // otherwise it opens a fresh frame
  assign new_frame = i_change && (!data_pend || send_data);

  always_ff @(posedge clk) begin
    if (i_reset) begin
      hdr_pend  <= 1'b0;
      data_pend <= 1'b0;
    end else begin
      if (send_hdr) begin
        hdr_pend <= 1'b0;
      end
      if (send_data) begin
        data_pend <= 1'b0;
      end
      // last assignment wins over the clears above
      if (new_frame) begin
        hdr_pend  <= 1'b1;
        data_pend <= 1'b1;
      end
    end
  end

  // one credit spent per offered byte, one returned per byte the
  // transmitter pulls from its queue
  always_ff @(posedge clk) begin
    if (i_reset) begin
      credit_cnt <= QCNT_W'(TX_CREDITS);
    end else begin
      credit_cnt <= credit_cnt - QCNT_W'(o_tx_valid) + QCNT_W'(i_credit);
    end
  end

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
// 8N1 uart transmitter with a small byte queue, hands back one credit per byte it starts sending
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_valid,
  input  logic [7:0] i_data,
  output logic       o_credit,
  output logic       o_tx
);
  import board_pkg::*;

  // byte queue, depth matches the sender's credits so it never overflows
  logic [7:0]                 queue_mem [TX_CREDITS];
  logic [QPTR_W-1:0]          wr_ptr;
  logic [QPTR_W-1:0]          rd_ptr;
  logic [QCNT_W-1:0]          q_count;

  // serializer state
  logic                       busy;
  logic [BAUD_CNT_W-1:0]      baud_cnt;
  logic [BIT_IDX_W-1:0]       bit_idx;
  // line bits, lsb is on the wire, ones shift in behind
  logic [UART_FRAME_BITS-1:0] shift_q;
  logic                       credit_q;

  logic                       bit_end;
  logic                       frame_end;
  logic                       deq;

  assign bit_end   = busy && (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));
  assign frame_end = bit_end && (bit_idx == BIT_IDX_W'(UART_FRAME_BITS - 1));
  // pull the next byte when idle, or right as the stop bit ends so
  // queued bytes go out back to back
  assign deq       = (q_count != '0) && (!busy || frame_end);

  // queue storage
  always_ff @(posedge clk) begin
    if (i_valid) begin
      queue_mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (i_valid) begin
        wr_ptr <= (wr_ptr == QPTR_W'(TX_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq) begin
        rd_ptr <= (rd_ptr == QPTR_W'(TX_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      q_count <= q_count + QCNT_W'(i_valid) - QCNT_W'(deq);
    end
  end

  // bit timing and shifting
  always_ff @(posedge clk) begin
    if (i_reset) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      shift_q  <= '1;
    end else if (deq) begin
      // stop bit, data lsb first, start bit
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      shift_q  <= {1'b1, queue_mem[rd_ptr], 1'b0};
    end else if (busy) begin
      if (bit_end) begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 1'b1;
        shift_q  <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
        // stop bit done and nothing queued
        if (frame_end) begin
          busy <= 1'b0;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // queue slot freed, tell the sender
  always_ff @(posedge clk) begin
    if (i_reset) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= deq;
    end
  end

  assign o_credit = credit_q;
  // idle line sits high since the shifter is full of ones
  assign o_tx     = shift_q[0];

endmodule

`default_nettype wire

// ==== source/board_top.sv ====
// board top level, switches in through the debouncer, state out on leds and the uart line
`timescale 1ns/1ps
`default_nettype none

module board_top (
  input  logic                              clk,
  input  logic                              i_reset,
  input  logic [board_pkg::NUM_SWITCHES-1:0] i_switch,
  output logic [board_pkg::NUM_LEDS-1:0]     o_led,
  output logic                              o_uart_tx
);
  import board_pkg::*;

  // debouncer to reporter
  logic [NUM_SWITCHES-1:0] filt_state;
  logic                    filt_change;

  // reporter to transmitter, credit flow
  logic                    tx_valid;
  logic [7:0]              tx_data;
  logic                    tx_credit;

  // asynchronous pins cleaned up here
  switch_filter switch_filter_inst (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_switch (i_switch),
    .o_state  (filt_state),
    .o_change (filt_change)
  );

  // led drive and report framing
  status_reporter status_reporter_inst (
    .clk        (clk),
    .i_reset    (i_reset),
    .i_state    (filt_state),
    .i_change   (filt_change),
    .i_credit   (tx_credit),
    .o_led      (o_led),
    .o_tx_valid (tx_valid),
    .o_tx_data  (tx_data)
  );

  // serial output
  uart_tx uart_tx_inst (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_valid  (tx_valid),
    .i_data   (tx_data),
    .o_credit (tx_credit),
    .o_tx     (o_uart_tx)
  );

endmodule

`default_nettype wire

// ==== verification/uart_rx_model.sv ====
// behavioral 8N1 receiver for the testbench, samples the line at mid-bit and pulses o_valid per byte
`timescale 1ns/1ps
`default_nettype none

module uart_rx_model (
  input  logic       clk,
  input  logic       i_rx,
  output logic [7:0] o_data,
  output logic       o_valid,
  output logic       o_frame_ok
);
  import board_pkg::*;

  logic [7:0] shift;
  logic       frame_ok;

  // line moves on the rising edge, so look at it on the falling edge
  initial begin
    o_data     = '0;
    o_valid    = 1'b0;
    o_frame_ok = 1'b0;
    forever begin
      @(negedge clk);
      if (i_rx == 1'b0) begin
        // first low sample sits about half a clock into the start bit
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        frame_ok = (i_rx == 1'b0);
        // data bits, lsb first
        for (int b = 0; b < 8; b++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          shift[b] = i_rx;
        end
        // stop bit must be high
        repeat (CLKS_PER_BIT) @(negedge clk);
        frame_ok   = frame_ok && (i_rx == 1'b1);
        o_data     = shift;
        o_frame_ok = frame_ok;
        o_valid    = 1'b1;
        @(negedge clk);
        o_valid = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/board_top_props.sv ====
// bound checks on board_top for the idle line after reset, transmit credits and led stability
`timescale 1ns/1ps
`default_nettype none

module board_top_props (
  input logic                             clk,
  input logic                             i_reset,
  input logic [board_pkg::NUM_LEDS-1:0]   i_led,
  input logic                             i_uart_tx,
  input logic                             i_change,
  input logic                             i_tx_valid,
  input logic                             i_tx_credit
);
  import board_pkg::*;

  // credits the reporter should hold, rebuilt from the handshake
  int credit_model;
  // read by the testbench at the end of the run
  int assert_failures = 0;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      credit_model <= TX_CREDITS;
    end else begin
      credit_model <= credit_model - int'(i_tx_valid) + int'(i_tx_credit);
    end
  end

  // line idle and leds dark right after reset
  idle_after_reset: assert property (@(posedge clk) i_reset |=> (i_uart_tx && i_led == '0))
    else begin
      $error("uart line or leds not idle after reset");
      assert_failures++;
    end

  // credits stay within the queue depth
  credit_bounds: assert property (@(posedge clk) disable iff (i_reset)
    (credit_model >= 0) && (credit_model <= TX_CREDITS))
    else begin
      $error("credit count out of range: %0d", credit_model);
      assert_failures++;
    end

  // leds only move on the cycle after an accepted change
  led_stable: assert property (@(posedge clk) disable iff (i_reset)
    $changed(i_led) |-> $past(i_change))
    else begin
      $error("leds changed without an accepted switch change");
      assert_failures++;
    end

endmodule

bind board_top board_top_props board_top_props_inst (
  .clk         (clk),
  .i_reset     (i_reset),
  .i_led       (o_led),
  .i_uart_tx   (o_uart_tx),
  .i_change    (filt_change),
  .i_tx_valid  (tx_valid),
  .i_tx_credit (tx_credit)
);

`default_nettype wire

// ==== verification/board_top_tb.sv ====
// self-checking testbench for board_top, applies a switch table and decodes the uart reports
`timescale 1ns/1ps
`default_nettype none

module board_top_tb;
  import board_pkg::*;

  localparam int CLK_PERIOD    = 4;
  localparam int RESET_CYCLES  = 3;
  localparam int BYTE_CYCLES   = UART_FRAME_BITS * CLKS_PER_BIT;
  localparam int FRAME_CYCLES  = 2 * BYTE_CYCLES;
  // sync plus filter delay, with room to spare
  localparam int SETTLE_CYCLES = 2 * FILTER_CYCLES;
  // longest pulse the filter must still reject
  localparam int GLITCH_CYCLES = FILTER_CYCLES - 1;
  // long enough for one more queued byte to show up
  localparam int QUIET_CYCLES  = BYTE_CYCLES + 20;
  localparam int NUM_ENTRIES   = 24;
  localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 2 * FRAME_CYCLES + 2000;

  logic                    clk;
  logic                    reset;
  logic [NUM_SWITCHES-1:0] switches;
  logic [NUM_LEDS-1:0]     leds;
  logic                    uart_line;
  logic [7:0]              rx_data;
  logic                    rx_valid;
  logic                    rx_frame_ok;
  logic [7:0]              rx_bytes [$];

  // reference model of the count and accepted state
  logic [CHG_CNT_W-1:0]    model_count;
  logic [NUM_SWITCHES-1:0] model_state;
  int                      pending_changes;

  // {switch value, glitch, expect report}
  // entries 0-18 walk the counter through a wrap, 19-21 are a burst
  logic [5:0] stim_table [NUM_ENTRIES] = '{
    {4'h1, 2'b01}, {4'h3, 2'b01}, {4'h7, 2'b10}, {4'h2, 2'b01}, {4'h2, 2'b00},
    {4'h6, 2'b01}, {4'he, 2'b01}, {4'hf, 2'b01}, {4'h0, 2'b10}, {4'h9, 2'b01},
    {4'h8, 2'b01}, {4'hc, 2'b01}, {4'h4, 2'b01}, {4'h5, 2'b01}, {4'hd, 2'b01},
    {4'hb, 2'b01}, {4'ha, 2'b01}, {4'h0, 2'b01}, {4'h3, 2'b01}, {4'h5, 2'b00},
    {4'h6, 2'b00}, {4'h9, 2'b01}, {4'h1, 2'b10}, {4'hf, 2'b01}
  };

  board_top board_top_inst (
    .clk       (clk),
    .i_reset   (reset),
    .i_switch  (switches),
    .o_led     (leds),
    .o_uart_tx (uart_line)
  );

  uart_rx_model uart_rx_model_inst (
    .clk        (clk),
    .i_rx       (uart_line),
    .o_data     (rx_data),
    .o_valid    (rx_valid),
    .o_frame_ok (rx_frame_ok)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // receiver hands over one byte per pulse
  always @(posedge clk) begin
    if (rx_valid) begin
      check_value("uart start/stop bits", 1, rx_frame_ok);
      rx_bytes.push_back(rx_data);
    end
  end

  // pins move shortly after the clock edge
  task automatic drive_switches(input logic [NUM_SWITCHES-1:0] value);
    @(posedge clk);
    #1;
    switches = value;
  endtask

  task automatic wait_for_bytes(input int n);
    int waited;
    waited = 0;
    while (rx_bytes.size() < n && waited < 2 * FRAME_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (rx_bytes.size() < n) begin
      $display("timed out waiting for %0d bytes on the uart line", n);
      $display("** FAIL **");
      $fatal(1, "uart receive timeout");
    end
  endtask

  // frames of a burst may show older states, the last one must be current
  task automatic collect_frames(input string name);
    logic [7:0] expected;
    logic [7:0] header;
    logic [7:0] data;
    int         frames;
    expected = {model_count, model_state};
    frames   = 0;
    data     = ~expected;
    while (data != expected) begin
      wait_for_bytes(2);
      header = rx_bytes.pop_front();
      data   = rx_bytes.pop_front();
      frames++;
      check_value({name, " header"}, FRAME_HEADER, header);
      if (frames >= pending_changes) begin
        check_value({name, " data"}, expected, data);
      end
    end
    pending_changes = 0;
  endtask

  // nothing more on the line, leds show the model
  task automatic expect_quiet(input string name);
    repeat (QUIET_CYCLES) @(negedge clk);
    check_value({name, " extra bytes"}, 0, rx_bytes.size());
    check_value({name, " led"}, {model_count, model_state}, leds);
  endtask

  task automatic apply_entry(input int idx);
    logic [NUM_SWITCHES-1:0] value;
    logic                    glitch;
    logic                    report;
    string                   name;
    {value, glitch, report} = stim_table[idx];
    name = $sformatf("entry %0d", idx);
    if (glitch) begin
      // pulse shorter than the filter, then back to the accepted value
      drive_switches(value);
      repeat (GLITCH_CYCLES - 1) @(posedge clk);
      drive_switches(model_state);
      expect_quiet(name);
    end else begin
      drive_switches(value);
      repeat (SETTLE_CYCLES) @(posedge clk);
      if (value != model_state) begin
        model_count = model_count + 1'b1;
        model_state = value;
        pending_changes++;
      end
      if (report) begin
        collect_frames(name);
        expect_quiet(name);
      end
    end
  endtask

  initial begin
    reset           = 1'b1;
    switches        = '0;
    model_count     = '0;
    model_state     = '0;
    pending_changes = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    // idle line and dark leds before any change
    repeat (4 * FILTER_CYCLES) begin
      @(negedge clk);
      check_value("idle line", 1, uart_line);
      check_value("idle led", 0, leds);
    end
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      apply_entry(i);
    end
    if (board_top_inst.board_top_props_inst.assert_failures == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("bound assertions failed %0d times",
               board_top_inst.board_top_props_inst.assert_failures);
      $display("** FAIL **");
      $fatal(1, "assertion failures");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("** FAIL **");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

// ==== board_top.f ====
source/board_pkg.sv
source/switch_filter.sv
source/status_reporter.sv
source/uart_tx.sv
source/board_top.sv
verification/uart_rx_model.sv
verification/board_top_props.sv
verification/board_top_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the board_top testbench with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f board_top.f \
  --top-module board_top_tb -o board_top_sim > "$LOG" 2>&1 \
  && ./obj_dir/board_top_sim >> "$LOG" 2>&1 \
  || echo "** FAIL **" >> "$LOG"
cat "$LOG"
grep -qF -- "** FAIL **" "$LOG" && echo "simulation failed" && exit 1
echo "simulation passed"
exit 0
